//--- design/nebula_pkg.sv
// ------------------------------------------------------------
// Address bits 15:12 pick the region. Higher bits are ignored
// Index 0 of the team bank and LA arrays is the idle default
// ------------------------------------------------------------
package nebula_pkg;

    localparam int GPIO_W  = 38;   // IO pins on the user area
    localparam int LA_W    = 32;
    localparam int SRAM_AW = 8;    // 256 words

    // Region numbers, team k sits at REGION_TEAM0 + k - 1
    localparam int REGION_SRAM  = 0;
    localparam int REGION_GPIO  = 1;
    localparam int REGION_LA    = 2;
    localparam int REGION_TEAM0 = 3;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // One team's drive onto the IO bank
    typedef struct packed {
        logic [GPIO_W-1:0] out;
        logic [GPIO_W-1:0] oeb;   // Active low
    } pin_bank_t;

endpackage

//--- design/wb_arbiter.sv
// ------------------------------------------------------------
// Two managers only. Grant changes only while the owner's cyc is low
// ------------------------------------------------------------
`timescale 1ns/1ps

module wb_arbiter
    import nebula_pkg::*;
(
    input  logic             wb_clk_i,
    input  logic             rst_i,
    input  wb_req_t [1:0]    m_req_i,
    output wb_rsp_t [1:0]    m_rsp_o,
    output wb_req_t          s_req_o,
    input  wb_rsp_t          s_rsp_i
);

    logic grant_vld_q;   // Someone owns the bus
    logic grant_idx_q;
    logic last_q;        // Manager served most recently
    logic bus_idle;
    logic pick;

    assign bus_idle = !grant_vld_q || !m_req_i[grant_idx_q].cyc;

    // Round robin only matters when both ask at once
    always_comb begin
        if (m_req_i[0].cyc && m_req_i[1].cyc) begin
            pick = ~last_q;
        end else begin
            pick = m_req_i[1].cyc;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            grant_vld_q <= 1'b0;
            grant_idx_q <= 1'b0;
            last_q      <= 1'b1;   // Manager A goes first on a tie
        end else if (bus_idle) begin
            grant_vld_q <= m_req_i[0].cyc || m_req_i[1].cyc;
            if (m_req_i[0].cyc || m_req_i[1].cyc) begin
                grant_idx_q <= pick;
                last_q      <= pick;
            end
        end
    end

    assign s_req_o = grant_vld_q ? m_req_i[grant_idx_q] : '0;

    // Non-owner sees a quiet response
    always_comb begin
        for (int m = 0; m < 2; m++) begin
            m_rsp_o[m] = (grant_vld_q && grant_idx_q == m[0]) ? s_rsp_i : '0;
        end
    end

endmodule

//--- design/wb_decoder.sv
// ------------------------------------------------------------
// Unmapped regions get an ack with zero data after one cycle
// ------------------------------------------------------------
`timescale 1ns/1ps

module wb_decoder
    import nebula_pkg::*;
#(
    parameter int NUM_TEAMS = 2
) (
    input  logic    wb_clk_i,
    input  logic    rst_i,
    input  wb_req_t m_req_i,
    output wb_rsp_t m_rsp_o,
    output wb_req_t p_req_o [0:REGION_TEAM0+NUM_TEAMS-1],
    input  wb_rsp_t p_rsp_i [0:REGION_TEAM0+NUM_TEAMS-1]
);

    localparam int NUM_P = REGION_TEAM0 + NUM_TEAMS;

    logic [NUM_P-1:0] hit;   // One-hot peripheral select
    logic             mapped;
    logic             err_ack_q;

    always_comb begin
        for (int k = 0; k < NUM_P; k++) begin
            hit[k] = (int'(m_req_i.adr[15:12]) == k);
        end
    end

    assign mapped = |hit;

    // Shared fields everywhere, cyc and stb only to the hit
    always_comb begin
        for (int k = 0; k < NUM_P; k++) begin
            p_req_o[k]     = m_req_i;
            p_req_o[k].cyc = m_req_i.cyc && hit[k];
            p_req_o[k].stb = m_req_i.stb && hit[k];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= m_req_i.cyc && m_req_i.stb && !mapped && !err_ack_q;
        end
    end

    always_comb begin
        m_rsp_o = '0;
        for (int k = 0; k < NUM_P; k++) begin
            if (hit[k]) begin
                m_rsp_o = p_rsp_i[k];
            end
        end
        if (err_ack_q) begin
            m_rsp_o = '{ack: 1'b1, dat: '0};   // Nothing lives here
        end
    end

endmodule

//--- design/wb_sram.sv
// ------------------------------------------------------------
// Flop-based stand-in for an SRAM macro, contents not reset
// ------------------------------------------------------------
`timescale 1ns/1ps

module wb_sram
    import nebula_pkg::*;
(
    input  logic    wb_clk_i,
    input  logic    rst_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    logic [31:0]        mem [0:2**SRAM_AW-1];
    logic [SRAM_AW-1:0] addr;
    logic [31:0]        rdata_q;
    logic               ack_q;
    logic               access;

    assign addr   = req_i.adr[SRAM_AW+1:2];   // Word address
    assign access = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= mem[addr];
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.sel[b]) mem[addr][8*b +: 8] <= req_i.dat[8*b +: 8];
                end
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

endmodule

//--- design/gpio_control.sv
// ------------------------------------------------------------
// One select register covers the whole bank, no per-pin routing
// ------------------------------------------------------------
`timescale 1ns/1ps

module gpio_control
    import nebula_pkg::*;
#(
    parameter int NUM_TEAMS = 2
) (
    input  logic              wb_clk_i,
    input  logic              rst_i,
    input  wb_req_t           req_i,
    output wb_rsp_t           rsp_o,
    input  pin_bank_t         banks_i [0:NUM_TEAMS],
    output logic [GPIO_W-1:0] io_out_o,
    output logic [GPIO_W-1:0] io_oeb_o
);

    localparam int SEL_W = $clog2(NUM_TEAMS + 1);

    logic [SEL_W-1:0] sel_q;   // 0 selects the idle default bank
    logic             ack_q;
    logic             access;
    logic             wr_sel;

    assign access = req_i.cyc && req_i.stb && !ack_q;
    assign wr_sel = access && req_i.we && (req_i.adr[11:2] == '0);

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            sel_q <= '0;
        end else begin
            ack_q <= access;
            if (wr_sel) begin
                // Out of range team falls back to default
                if (req_i.dat > 32'(NUM_TEAMS)) begin
                    sel_q <= '0;
                end else begin
                    sel_q <= req_i.dat[SEL_W-1:0];
                end
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = 32'(sel_q);

    assign io_out_o = banks_i[sel_q].out;
    assign io_oeb_o = banks_i[sel_q].oeb;

endmodule

//--- design/la_control.sv
// ------------------------------------------------------------
// Output side of the LA only, no input or enable bus
// ------------------------------------------------------------
`timescale 1ns/1ps

module la_control
    import nebula_pkg::*;
#(
    parameter int NUM_TEAMS = 2
) (
    input  logic            wb_clk_i,
    input  logic            rst_i,
    input  wb_req_t         req_i,
    output wb_rsp_t         rsp_o,
    input  logic [LA_W-1:0] la_words_i [0:NUM_TEAMS],
    output logic [LA_W-1:0] la_data_o
);

    localparam int SEL_W = $clog2(NUM_TEAMS + 1);

    logic [SEL_W-1:0] sel_q;
    logic             ack_q;
    logic             access;

    assign access = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            sel_q <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we && req_i.adr[11:2] == '0) begin
                sel_q <= (req_i.dat > 32'(NUM_TEAMS)) ? '0 : req_i.dat[SEL_W-1:0];
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = 32'(sel_q);   // Readback of current select

    assign la_data_o = la_words_i[sel_q];

endmodule

//--- design/team_accumulator.sv
// ------------------------------------------------------------
// Offset 0 adds, offset 4 clears, any read returns the sum
// ------------------------------------------------------------
`timescale 1ns/1ps

module team_accumulator
    import nebula_pkg::*;
(
    input  logic            wb_clk_i,
    input  logic            rst_i,
    input  wb_req_t         req_i,
    output wb_rsp_t         rsp_o,
    output pin_bank_t       bank_o,
    output logic [LA_W-1:0] la_o
);

    logic [31:0] acc_q;
    logic        ack_q;
    logic        wr;

    assign wr = req_i.cyc && req_i.stb && !ack_q && req_i.we;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            acc_q <= '0;
        end else begin
            ack_q <= req_i.cyc && req_i.stb && !ack_q;
            if (wr && req_i.adr[11:2] == 10'd0) begin
                acc_q <= acc_q + req_i.dat;   // Wraps mod 2^32
            end else if (wr && req_i.adr[11:2] == 10'd1) begin
                acc_q <= '0;
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = acc_q;

    assign bank_o.out = GPIO_W'(acc_q);
    assign bank_o.oeb = '0;   // All pins driven
    assign la_o       = ~acc_q;

endmodule

//--- design/nebula_top.sv
// ------------------------------------------------------------
// NUM_TEAMS from 1 to 12. No power pins, IRQs or LA inputs
// ------------------------------------------------------------
`timescale 1ns/1ps

module nebula_top
    import nebula_pkg::*;
#(
    parameter int NUM_TEAMS = 2
) (
    input  logic              wb_clk_i,
    input  logic              rst_i,
    input  wb_req_t           host_a_req_i,
    output wb_rsp_t           host_a_rsp_o,
    input  wb_req_t           host_b_req_i,
    output wb_rsp_t           host_b_rsp_o,
    output logic [GPIO_W-1:0] io_out_o,
    output logic [GPIO_W-1:0] io_oeb_o,
    output logic [LA_W-1:0]   la_data_o
);

    localparam int NUM_P = REGION_TEAM0 + NUM_TEAMS;

    wb_req_t [1:0]   m_req;
    wb_rsp_t [1:0]   m_rsp;
    wb_req_t         bus_req;
    wb_rsp_t         bus_rsp;
    wb_req_t         p_req [0:NUM_P-1];
    wb_rsp_t         p_rsp [0:NUM_P-1];
    pin_bank_t       banks [0:NUM_TEAMS];
    logic [LA_W-1:0] la_words [0:NUM_TEAMS];

    assign m_req        = {host_b_req_i, host_a_req_i};   // A is manager 0
    assign host_a_rsp_o = m_rsp[0];
    assign host_b_rsp_o = m_rsp[1];

    // Default when no team is selected
    assign banks[0]    = '{out: '0, oeb: '1};
    assign la_words[0] = '0;

    wb_arbiter u_arbiter (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .m_req_i  (m_req),
        .m_rsp_o  (m_rsp),
        .s_req_o  (bus_req),
        .s_rsp_i  (bus_rsp)
    );

    wb_decoder #(.NUM_TEAMS(NUM_TEAMS)) u_decoder (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .m_req_i  (bus_req),
        .m_rsp_o  (bus_rsp),
        .p_req_o  (p_req),
        .p_rsp_i  (p_rsp)
    );

    wb_sram u_sram (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .req_i    (p_req[REGION_SRAM]),
        .rsp_o    (p_rsp[REGION_SRAM])
    );

    gpio_control #(.NUM_TEAMS(NUM_TEAMS)) u_gpio (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .req_i    (p_req[REGION_GPIO]),
        .rsp_o    (p_rsp[REGION_GPIO]),
        .banks_i  (banks),
        .io_out_o (io_out_o),
        .io_oeb_o (io_oeb_o)
    );

    la_control #(.NUM_TEAMS(NUM_TEAMS)) u_la (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .req_i      (p_req[REGION_LA]),
        .rsp_o      (p_rsp[REGION_LA]),
        .la_words_i (la_words),
        .la_data_o  (la_data_o)
    );

    for (genvar t = 1; t <= NUM_TEAMS; t++) begin : g_team
        team_accumulator u_team (
            .wb_clk_i (wb_clk_i),
            .rst_i    (rst_i),
            .req_i    (p_req[REGION_TEAM0+t-1]),
            .rsp_o    (p_rsp[REGION_TEAM0+t-1]),
            .bank_o   (banks[t]),
            .la_o     (la_words[t])
        );
    end

endmodule

//--- bench/nebula_tb.sv
// ------------------------------------------------------------
// Runs with NUM_TEAMS = 2. Under contention the two hosts use
// disjoint addresses, so the model does not depend on ack order
// ------------------------------------------------------------
`timescale 1ns/1ps

module nebula_tb
    import nebula_pkg::*;
();

    localparam int NT       = 2;
    localparam int N_SRAM   = 24;
    localparam int N_TEAM   = 24;
    localparam int N_ROUNDS = 16;
    localparam int N_UNMAP  = 16;
    localparam int TOTAL_TX = N_SRAM * 4 + N_TEAM * 3 + (NT + 2) * 4 + 4
                            + N_ROUNDS * 8 + N_UNMAP * 4;

    logic              clk;
    logic              rst_i;
    wb_req_t           a_req;
    wb_req_t           b_req;
    wb_rsp_t           a_rsp;
    wb_rsp_t           b_rsp;
    logic [GPIO_W-1:0] io_out;
    logic [GPIO_W-1:0] io_oeb;
    logic [LA_W-1:0]   la_data;

    // Reference state
    logic [31:0] sram_m [0:255];
    logic [31:0] acc_m [1:NT] = '{default: '0};
    logic [31:0] gsel_m = '0;
    logic [31:0] lsel_m = '0;

    string        name_q [$];
    logic [107:0] exp_q [$];
    logic [107:0] act_q [$];
    bit           pin_q [$];   // Entry compares the live pins
    logic [107:0] cmp_act;
    int           tx_cnt [0:1] = '{0, 0};
    int           ack_cnt [0:1] = '{0, 0};

    nebula_top #(.NUM_TEAMS(NT)) dut (
        .wb_clk_i     (clk),
        .rst_i        (rst_i),
        .host_a_req_i (a_req),
        .host_a_rsp_o (a_rsp),
        .host_b_req_i (b_req),
        .host_b_rsp_o (b_rsp),
        .io_out_o     (io_out),
        .io_oeb_o     (io_oeb),
        .la_data_o    (la_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] make_adr(input int region, input int word);
        return {16'h0, 4'(region), 10'(word), 2'b00};
    endfunction

    // Expected read data for any address
    function automatic logic [31:0] ref_read(input logic [31:0] adr);
        int region;
        region = int'(adr[15:12]);
        case (region)
            REGION_SRAM: return sram_m[adr[9:2]];
            REGION_GPIO: return gsel_m;
            REGION_LA:   return lsel_m;
            default: begin
                if (region - REGION_TEAM0 < NT) begin
                    return acc_m[region - REGION_TEAM0 + 1];
                end
                return 32'h0;   // Unmapped
            end
        endcase
    endfunction

    function automatic void model_write(input logic [31:0] adr, dat, input logic [3:0] sel);
        int region;
        int team;
        region = int'(adr[15:12]);
        team   = region - REGION_TEAM0 + 1;
        if (region == REGION_SRAM) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    sram_m[adr[9:2]][8*b +: 8] = dat[8*b +: 8];   // Byte merge
                end
            end
        end else if (region == REGION_GPIO && adr[11:2] == 0) begin
            gsel_m = (dat > NT) ? 32'd0 : dat;
        end else if (region == REGION_LA && adr[11:2] == 0) begin
            lsel_m = (dat > NT) ? 32'd0 : dat;
        end else if (team >= 1 && team <= NT) begin
            if (adr[11:2] == 0) begin
                acc_m[team] = acc_m[team] + dat;
            end else if (adr[11:2] == 1) begin
                acc_m[team] = '0;
            end
        end
    endfunction

    // io_out, io_oeb and la_data as the model sees them
    function automatic logic [107:0] pins_model();
        logic [GPIO_W-1:0] out;
        logic [GPIO_W-1:0] oeb;
        logic [LA_W-1:0]   la;
        out = '0;
        oeb = '1;
        la  = '0;
        if (gsel_m != 0) begin
            out = GPIO_W'(acc_m[gsel_m]);
            oeb = '0;
        end
        if (lsel_m != 0) begin
            la = ~acc_m[lsel_m];
        end
        return {out, oeb, la};
    endfunction

    function automatic void push_check(input string name, input logic [107:0] exp, act,
                                       input bit pins);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
        pin_q.push_back(pins);
    endfunction

    task automatic check_value(input string name, input logic [107:0] exp, act);
        if (act !== exp) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // One single read or write on host 0 (A) or host 1 (B)
    task automatic bus_xfer(input int host, input logic we, input logic [31:0] adr, dat,
                            input logic [3:0] sel, input string name);
        wb_req_t     req;
        logic [31:0] rdata;
        req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
        @(negedge clk);
        if (host == 0) begin
            a_req = req;
        end else begin
            b_req = req;
        end
        do begin
            @(negedge clk);
        end while (!((host == 0) ? a_rsp.ack : b_rsp.ack));
        rdata = (host == 0) ? a_rsp.dat : b_rsp.dat;
        if (host == 0) begin
            a_req = '0;
        end else begin
            b_req = '0;
        end
        tx_cnt[host]++;
        if (we) begin
            model_write(adr, dat, sel);
            push_check({name, " pins"}, pins_model(), '0, 1'b1);
        end else begin
            push_check(name, 108'(ref_read(adr)), 108'(rdata), 1'b0);
        end
    endtask

    // Pins still hold their pre-edge values here
    always @(posedge clk) begin
        while (name_q.size() > 0) begin
            cmp_act = act_q.pop_front();
            if (pin_q.pop_front()) begin
                cmp_act = {io_out, io_oeb, la_data};
            end
            check_value(name_q.pop_front(), exp_q.pop_front(), cmp_act);
        end
    end

    // Each ack pulse counted once on its rising edge
    always @(posedge a_rsp.ack) begin
        if (!rst_i) begin
            ack_cnt[0]++;
        end
    end

    always @(posedge b_rsp.ack) begin
        if (!rst_i) begin
            ack_cnt[1]++;
        end
    end

    initial begin
        repeat (TOTAL_TX * 20 + 200) @(posedge clk);
        $display("Watchdog expired, the bus hung");
        $display("sim failed");
        $fatal(1, "Timeout");
    end

    initial begin
        logic [31:0] adr;
        logic [31:0] adr_b;
        logic [31:0] dat;
        logic [31:0] dat_b;
        logic [31:0] known;   // An SRAM word that holds data
        int          t;
        void'($urandom(32'h549b_61f8));
        rst_i = 1'b1;
        a_req = '0;
        b_req = '0;
        repeat (4) @(negedge clk);
        rst_i = 1'b0;
        push_check("reset pins", pins_model(), '0, 1'b1);

        for (int i = 0; i < N_SRAM; i++) begin
            known = make_adr(REGION_SRAM, $urandom_range(255));
            bus_xfer(0, 1, known, $urandom, 4'hf, "sram full write");
            bus_xfer(1, 1, known, $urandom, 4'($urandom), "sram byte write");
            bus_xfer(0, 0, known, '0, 4'hf, "sram read A");
            bus_xfer(1, 0, known, '0, 4'hf, "sram read B");
        end

        for (int i = 0; i < N_TEAM; i++) begin
            t = REGION_TEAM0 + $urandom_range(NT - 1);
            if ($urandom_range(7) == 0) begin
                bus_xfer(i % 2, 1, make_adr(t, 1), $urandom, 4'hf, "team clear");
            end else begin
                bus_xfer(i % 2, 1, make_adr(t, 0), $urandom, 4'hf, "team add");
            end
            bus_xfer(0, 0, make_adr(REGION_TEAM0, 0), '0, 4'hf, "team 1 read");
            bus_xfer(1, 0, make_adr(REGION_TEAM0 + 1, $urandom_range(1023)), '0, 4'hf,
                     "team 2 read");
        end

        // Last value is above NUM_TEAMS and falls back to 0
        for (int v = 0; v <= NT + 1; v++) begin
            bus_xfer(0, 1, make_adr(REGION_GPIO, 0), v, 4'hf, "gpio select");
            bus_xfer(1, 0, make_adr(REGION_GPIO, 0), '0, 4'hf, "gpio readback");
            bus_xfer(1, 1, make_adr(REGION_LA, 0), v, 4'hf, "la select");
            bus_xfer(0, 0, make_adr(REGION_LA, 0), '0, 4'hf, "la readback");
        end
        bus_xfer(0, 1, make_adr(REGION_GPIO, 0), 32'hffff_fff1, 4'hf, "gpio select high");
        bus_xfer(1, 0, make_adr(REGION_GPIO, 0), '0, 4'hf, "gpio readback high");
        bus_xfer(0, 1, make_adr(REGION_GPIO, 0), 1, 4'hf, "gpio select team 1");
        bus_xfer(1, 1, make_adr(REGION_LA, 0), 2, 4'hf, "la select team 2");

        for (int r = 0; r < N_ROUNDS; r++) begin
            adr   = make_adr(REGION_SRAM, $urandom_range(127));         // Lower half for A
            adr_b = make_adr(REGION_SRAM, 128 + $urandom_range(127));
            dat   = $urandom;
            dat_b = $urandom;
            fork
                begin
                    bus_xfer(0, 1, adr, dat, 4'hf, "race sram write A");
                    bus_xfer(0, 0, adr, '0, 4'hf, "race sram read A");
                    bus_xfer(0, 1, make_adr(REGION_TEAM0, 0), dat, 4'hf, "race team 1 add");
                    bus_xfer(0, 0, make_adr(REGION_TEAM0, 0), '0, 4'hf, "race team 1 read");
                end
                begin
                    bus_xfer(1, 1, adr_b, dat_b, 4'hf, "race sram write B");
                    bus_xfer(1, 0, adr_b, '0, 4'hf, "race sram read B");
                    bus_xfer(1, 1, make_adr(REGION_TEAM0 + 1, 0), dat_b, 4'hf, "race team 2 add");
                    bus_xfer(1, 0, make_adr(REGION_TEAM0 + 1, 0), '0, 4'hf, "race team 2 read");
                end
            join
        end

        // Same low address bits as a live SRAM word
        for (int i = 0; i < N_UNMAP; i++) begin
            adr = {16'h0, 4'(REGION_TEAM0 + NT + $urandom_range(10)), known[11:0]};
            bus_xfer(i % 2, 1, adr, $urandom, 4'hf, "unmapped write");
            bus_xfer(i % 2, 0, adr, '0, 4'hf, "unmapped read");
            bus_xfer(0, 0, make_adr(REGION_TEAM0, 0), '0, 4'hf, "team 1 after unmapped");
            bus_xfer(1, 0, known, '0, 4'hf, "sram after unmapped");
        end

        repeat (2) @(posedge clk);
        wait (name_q.size() == 0);
        check_value("acks host A", 108'(tx_cnt[0]), 108'(ack_cnt[0]));
        check_value("acks host B", 108'(tx_cnt[1]), 108'(ack_cnt[1]));
        $display("sim passed");
        $finish;
    end

endmodule

//--- flist.f
design/nebula_pkg.sv
design/wb_arbiter.sv
design/wb_decoder.sv
design/wb_sram.sv
design/gpio_control.sv
design/la_control.sv
design/team_accumulator.sv
design/nebula_top.sv
bench/nebula_tb.sv
